//--- Bender.yml
package:
  name: mips_cpu

sources:
  - rtl/mips_pkg.sv
  - rtl/mips_regfile.sv
  - rtl/mips_alu.sv
  - rtl/mips_pc.sv
  - rtl/mips_control.sv
  - rtl/mips_cpu.sv
  - target: test
    files:
      - test/mips_cpu_props.sv
      - test/mips_cpu_tb.sv

//--- mips_cpu.f
rtl/mips_pkg.sv
rtl/mips_regfile.sv
rtl/mips_alu.sv
rtl/mips_pc.sv
rtl/mips_control.sv
rtl/mips_cpu.sv
test/mips_cpu_props.sv
test/mips_cpu_tb.sv

//--- rtl/mips_alu.sv
// combinational ALU; arithmetic wraps, unknown op codes give zero
`timescale 1ns/1ns

module mips_alu
  import mips_pkg::*;
(
  input  alu_op_t    op,
  input  word_t      a,
  input  word_t      b,
  input  logic [4:0] shamt,
  output word_t      result
);

  always_comb begin
    case (op)
      alu_add: begin
        result = a + b;
      end
      alu_sub: begin
        result = a - b;
      end
      alu_and: begin
        result = a & b;
      end
      alu_or: begin
        result = a | b;
      end
      alu_xor: begin
        result = a ^ b;
      end
      alu_slt: begin
        result = {31'b0, $signed(a) < $signed(b)};
      end
      alu_sltu: begin
        result = {31'b0, a < b};
      end
      // shifts act on the rt operand, as in the R-type encoding
      alu_sll: begin
        result = b << shamt;
      end
      alu_srl: begin
        result = b >> shamt;
      end
      alu_lui: begin
        result = {b[15:0], 16'b0};
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

//--- rtl/mips_control.sv
// multi-cycle control FSM; one request at a time, waits forever on a stalled bus
`timescale 1ns/1ns

module mips_control
  import mips_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  word_t      instr,
  input  logic       equal,
  input  logic       jump_reg_zero,
  input  logic       mem_ready,
  input  logic       mem_rvalid,
  output logic       mem_valid,
  output logic       mem_write,
  output logic       addr_sel,
  output logic       ir_load,
  output logic       mdr_load,
  output logic       pc_inc,
  output logic       pc_load,
  output logic [1:0] target_sel,
  output alu_op_t    alu_op,
  output logic [1:0] alu_b_sel,
  output logic       reg_write,
  output logic [1:0] dest_sel,
  output logic       wb_sel,
  output logic       active
);

  ctrl_state_t state;
  ctrl_state_t state_next;
  logic [5:0]  opcode;
  logic [5:0]  funct;
  logic        is_alu;
  logic        is_lw;
  logic        is_sw;
  logic        is_jr;
  logic        redirect;
  logic        accept;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];

  // decode is independent of state, the strobes below qualify it
  always_comb begin
    alu_op     = alu_add;
    alu_b_sel  = 2'd0;  // rt register
    dest_sel   = 2'd2;  // r0, nothing kept
    wb_sel     = 1'b0;  // alu result
    target_sel = 2'd0;  // branch target
    is_alu     = 1'b0;
    is_lw      = 1'b0;
    is_sw      = 1'b0;
    is_jr      = 1'b0;
    redirect   = 1'b0;
    case (opcode)
      op_special: begin
        dest_sel = 2'd0;  // rd
        is_alu   = 1'b1;
        case (funct)
          fn_addu: alu_op = alu_add;
          fn_subu: alu_op = alu_sub;
          fn_and:  alu_op = alu_and;
          fn_or:   alu_op = alu_or;
          fn_xor:  alu_op = alu_xor;
          fn_slt:  alu_op = alu_slt;
          fn_sltu: alu_op = alu_sltu;
          fn_sll:  alu_op = alu_sll;
          fn_srl:  alu_op = alu_srl;
          fn_jr: begin
            is_alu     = 1'b0;
            is_jr      = 1'b1;
            redirect   = 1'b1;
            target_sel = 2'd2;  // rs register
          end
          default: is_alu = 1'b0;  // unknown funct runs as a no-op
        endcase
      end
      op_addiu, op_slti: begin
        alu_op    = (opcode == op_slti) ? alu_slt : alu_add;
        alu_b_sel = 2'd1;  // sign-extended immediate
        dest_sel  = 2'd1;
        is_alu    = 1'b1;
      end
      op_andi, op_ori, op_xori, op_lui: begin
        case (opcode)
          op_andi: alu_op = alu_and;
          op_ori:  alu_op = alu_or;
          op_xori: alu_op = alu_xor;
          default: alu_op = alu_lui;
        endcase
        alu_b_sel = 2'd2;  // zero-extended immediate
        dest_sel  = 2'd1;
        is_alu    = 1'b1;
      end
      op_lw: begin
        alu_b_sel = 2'd1;
        dest_sel  = 2'd1;
        wb_sel    = 1'b1;  // loaded word
        is_lw     = 1'b1;
      end
      op_sw: begin
        alu_b_sel = 2'd1;
        is_sw     = 1'b1;
      end
      op_beq:  redirect = equal;
      op_bne:  redirect = !equal;
      op_j: begin
        redirect   = 1'b1;
        target_sel = 2'd1;
      end
      default: ;
    endcase
  end

  assign accept = mem_valid && mem_ready;

  always_comb begin
    state_next = state;
    case (state)
      fetch:      if (accept) state_next = fetch_wait;
      fetch_wait: if (mem_rvalid) state_next = execute;
      execute: begin
        if (is_jr && jump_reg_zero) begin
          state_next = halted;
        end else if (is_alu) begin
          state_next = writeback;
        end else if (is_lw || is_sw) begin
          state_next = mem_req;
        end else begin
          state_next = fetch;  // branches, jumps and no-ops retire here
        end
      end
      mem_req:    if (accept) state_next = is_sw ? fetch : mem_wait;
      mem_wait:   if (mem_rvalid) state_next = writeback;
      writeback:  state_next = fetch;
      default:    state_next = halted;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= fetch;
    end else begin
      state <= state_next;
    end
  end

  assign mem_valid = (state == fetch) || (state == mem_req);  // held until accepted
  assign mem_write = (state == mem_req) && is_sw;
  assign addr_sel  = (state == mem_req);  // data address comes from the alu
  assign ir_load   = (state == fetch_wait) && mem_rvalid;
  assign mdr_load  = (state == mem_wait) && mem_rvalid;
  assign pc_load   = (state == execute) && redirect;
  assign pc_inc    = (state == execute) && !redirect;
  assign reg_write = (state == writeback);
  assign active    = (state != halted);

endmodule

//--- rtl/mips_cpu.sv
// MIPS subset core top; big-endian memory, swaps bytes at the bus, halts on jr to address 0
`timescale 1ns/1ns

module mips_cpu
  import mips_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  output logic  mem_valid,
  output logic  mem_write,
  output word_t mem_addr,
  output word_t mem_wdata,
  input  logic  mem_ready,
  input  logic  mem_rvalid,
  input  word_t mem_rdata,
  output logic  active,
  output word_t register_v0
);

  word_t      ir;   // instruction register
  word_t      mdr;  // memory data register
  word_t      pc;
  word_t      pc_next_seq;
  word_t      pc_target;
  word_t      read_data_a;
  word_t      read_data_b;
  word_t      alu_b;
  word_t      alu_result;
  word_t      imm_sext;
  word_t      imm_zext;
  word_t      branch_target;
  word_t      jump_target;
  word_t      write_data;
  reg_addr_t  write_addr;
  alu_op_t    alu_op;
  logic       addr_sel;
  logic       ir_load;
  logic       mdr_load;
  logic       pc_inc;
  logic       pc_load;
  logic [1:0] target_sel;
  logic [1:0] alu_b_sel;
  logic       reg_write;
  logic [1:0] dest_sel;
  logic       wb_sel;
  logic       equal;
  logic       jump_reg_zero;

  function automatic word_t swap_bytes(input word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  always_ff @(posedge clk) begin
    if (ir_load) begin
      ir <= swap_bytes(mem_rdata);
    end
    if (mdr_load) begin
      mdr <= swap_bytes(mem_rdata);
    end
  end

  assign imm_sext      = {{16{ir[15]}}, ir[15:0]};
  assign imm_zext      = {16'b0, ir[15:0]};
  assign branch_target = pc_next_seq + {imm_sext[29:0], 2'b00};
  assign jump_target   = {pc_next_seq[31:28], ir[25:0], 2'b00};  // same 256 MB region

  assign equal         = (read_data_a == read_data_b);
  assign jump_reg_zero = (read_data_a == '0);

  always_comb begin
    case (alu_b_sel)
      2'd1:    alu_b = imm_sext;
      2'd2:    alu_b = imm_zext;
      default: alu_b = read_data_b;
    endcase
    case (target_sel)
      2'd0:    pc_target = branch_target;
      2'd1:    pc_target = jump_target;
      default: pc_target = read_data_a;  // jr
    endcase
    case (dest_sel)
      2'd0:    write_addr = ir[15:11];
      2'd1:    write_addr = ir[20:16];
      default: write_addr = '0;
    endcase
  end

  assign write_data = wb_sel ? mdr : alu_result;
  assign mem_addr   = addr_sel ? alu_result : pc;
  assign mem_wdata  = swap_bytes(read_data_b);  // sw stores rt

  mips_regfile u_regfile (
    .clk         (clk),
    .reset       (reset),
    .read_addr_a (ir[25:21]),
    .read_addr_b (ir[20:16]),
    .read_data_a (read_data_a),
    .read_data_b (read_data_b),
    .write_en    (reg_write),
    .write_addr  (write_addr),
    .write_data  (write_data),
    .v0          (register_v0)
  );

  mips_alu u_alu (
    .op     (alu_op),
    .a      (read_data_a),
    .b      (alu_b),
    .shamt  (ir[10:6]),
    .result (alu_result)
  );

  mips_pc u_pc (
    .clk         (clk),
    .reset       (reset),
    .inc         (pc_inc),
    .load        (pc_load),
    .target      (pc_target),
    .pc          (pc),
    .pc_next_seq (pc_next_seq)
  );

  mips_control u_control (
    .clk           (clk),
    .reset         (reset),
    .instr         (ir),
    .equal         (equal),
    .jump_reg_zero (jump_reg_zero),
    .mem_ready     (mem_ready),
    .mem_rvalid    (mem_rvalid),
    .mem_valid     (mem_valid),
    .mem_write     (mem_write),
    .addr_sel      (addr_sel),
    .ir_load       (ir_load),
    .mdr_load      (mdr_load),
    .pc_inc        (pc_inc),
    .pc_load       (pc_load),
    .target_sel    (target_sel),
    .alu_op        (alu_op),
    .alu_b_sel     (alu_b_sel),
    .reg_write     (reg_write),
    .dest_sel      (dest_sel),
    .wb_sel        (wb_sel),
    .active        (active)
  );

endmodule

//--- rtl/mips_pc.sv
// program counter; starts at the boot vector, load wins over increment
`timescale 1ns/1ns

module mips_pc
  import mips_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  inc,
  input  logic  load,
  input  word_t target,
  output word_t pc,
  output word_t pc_next_seq
);

  assign pc_next_seq = pc + 32'd4;  // also the base of branch offsets

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_vector;
    end else if (load) begin
      pc <= target;
    end else if (inc) begin
      pc <= pc_next_seq;
    end
  end

endmodule

//--- rtl/mips_pkg.sv
// shared types and encodings for the MIPS subset core; word accesses only, no delay slots
package mips_pkg;

  typedef logic [31:0] word_t;     // data word, address or instruction
  typedef logic [4:0]  reg_addr_t; // register number
  typedef logic [3:0]  alu_op_t;

  // alu operations
  localparam alu_op_t alu_add  = 4'd0;
  localparam alu_op_t alu_sub  = 4'd1;
  localparam alu_op_t alu_and  = 4'd2;
  localparam alu_op_t alu_or   = 4'd3;
  localparam alu_op_t alu_xor  = 4'd4;
  localparam alu_op_t alu_slt  = 4'd5;
  localparam alu_op_t alu_sltu = 4'd6;
  localparam alu_op_t alu_sll  = 4'd7;
  localparam alu_op_t alu_srl  = 4'd8;
  localparam alu_op_t alu_lui  = 4'd9;  // b shifted into the upper half

  // primary opcodes, instr[31:26]
  localparam logic [5:0] op_special = 6'h00;
  localparam logic [5:0] op_j       = 6'h02;
  localparam logic [5:0] op_beq     = 6'h04;
  localparam logic [5:0] op_bne     = 6'h05;
  localparam logic [5:0] op_addiu   = 6'h09;
  localparam logic [5:0] op_slti    = 6'h0a;
  localparam logic [5:0] op_andi    = 6'h0c;
  localparam logic [5:0] op_ori     = 6'h0d;
  localparam logic [5:0] op_xori    = 6'h0e;
  localparam logic [5:0] op_lui     = 6'h0f;
  localparam logic [5:0] op_lw      = 6'h23;
  localparam logic [5:0] op_sw      = 6'h2b;

  // funct field of special instructions, instr[5:0]
  localparam logic [5:0] fn_sll  = 6'h00;
  localparam logic [5:0] fn_srl  = 6'h02;
  localparam logic [5:0] fn_jr   = 6'h08;
  localparam logic [5:0] fn_addu = 6'h21;
  localparam logic [5:0] fn_subu = 6'h23;
  localparam logic [5:0] fn_and  = 6'h24;
  localparam logic [5:0] fn_or   = 6'h25;
  localparam logic [5:0] fn_xor  = 6'h26;
  localparam logic [5:0] fn_slt  = 6'h2a;
  localparam logic [5:0] fn_sltu = 6'h2b;

  localparam word_t reset_vector = 32'hBFC00000;  // first fetch address

  typedef enum logic [2:0] {
    fetch,
    fetch_wait,
    execute,
    mem_req,
    mem_wait,
    writeback,
    halted
  } ctrl_state_t;

endpackage

//--- rtl/mips_regfile.sv
// 32 x 32 register file, two async reads, one write per clock; register 0 always reads zero
`timescale 1ns/1ns

module mips_regfile
  import mips_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  reg_addr_t read_addr_a,
  input  reg_addr_t read_addr_b,
  output word_t     read_data_a,
  output word_t     read_data_b,
  input  logic      write_en,
  input  reg_addr_t write_addr,
  input  word_t     write_data,
  output word_t     v0
);

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en) begin
      regs[write_addr] <= write_data;  // a write to r0 lands but is never seen
    end
  end

  assign read_data_a = (read_addr_a == '0) ? '0 : regs[read_addr_a];
  assign read_data_b = (read_addr_b == '0) ? '0 : regs[read_addr_b];

  assign v0 = regs[2];  // result register shown at the top level

endmodule

//--- test/mips_cpu_props.sv
// concurrent checks bound into every mips_control; all disabled while reset is high
`timescale 1ns/1ns

module mips_cpu_props
  import mips_pkg::*;
(
  input logic        clk,
  input logic        reset,
  input ctrl_state_t state,
  input word_t       instr,
  input logic        jump_reg_zero,
  input logic        mem_valid,
  input logic        mem_ready,
  input logic        mem_write,
  input logic        active
);

  int unsigned error_count = 0;

  // a stalled request keeps its kind and everything its address comes from
  request_held: assert property (@(posedge clk) disable iff (reset)
      mem_valid && !mem_ready |=>
        mem_valid && $stable(mem_write) && $stable(state) && $stable(instr))
    else begin
      error_count++;
      $error("memory request changed before it was accepted");
    end

  // once stopped the core stays stopped and silent until the next reset
  quiet_when_halted: assert property (@(posedge clk) disable iff (reset)
      !active |-> !mem_valid ##1 !active)
    else begin
      error_count++;
      $error("memory request issued or core restarted after the halt");
    end

  // the only way to stop is a jr through a zero register
  active_until_halt: assert property (@(posedge clk) disable iff (reset)
      $fell(active) |->
        $past(state == execute && instr[31:26] == op_special && instr[5:0] == fn_jr
              && jump_reg_zero))
    else begin
      error_count++;
      $error("active fell without a jr to address zero");
    end

endmodule

bind mips_control mips_cpu_props u_props (.*);

//--- test/mips_cpu_tb.sv
// directed testbench for mips_cpu; word-aligned big-endian memory model, programs at reset_vector
`timescale 1ns/1ns

module mips_cpu_tb
  import mips_pkg::*;
;

  localparam int clk_period_ns = 8;
  localparam int program_insns = 22 + 14 + 9 + 22 + 2 + 22;  // dynamic count of the six runs
  localparam int worst_cpi     = 64;  // two long stalls, two slow reads, execute, writeback
  localparam int run_overhead  = 64;  // reset, drain and the quiet window after halt
  localparam int watchdog_ns   =
    2 * clk_period_ns * (program_insns * worst_cpi + 6 * run_overhead);

  localparam reg_addr_t r_zero = 5'd0;
  localparam reg_addr_t r_v0   = 5'd2;
  localparam reg_addr_t r_t0   = 5'd8;
  localparam reg_addr_t r_t1   = 5'd9;
  localparam reg_addr_t r_t2   = 5'd10;
  localparam reg_addr_t r_t3   = 5'd11;

  logic  clk = 1'b0;
  logic  reset;
  logic  mem_valid;
  logic  mem_write;
  word_t mem_addr;
  word_t mem_wdata;
  logic  mem_ready;
  logic  mem_rvalid;
  word_t mem_rdata;
  logic  active;
  word_t register_v0;

  word_t mem [word_t];     // bus-lane words, lane 0 holds the byte at the word address
  word_t program_q [$];
  word_t rng_state = 32'd57695;
  logic  stall_mode = 1'b0;  // long ready-low stretches
  logic  read_pending;
  int    read_delay;
  word_t read_addr;
  int    stretch;
  logic  seen_request;
  word_t first_addr;
  logic  first_write;

  mips_cpu uut (
    .clk         (clk),
    .reset       (reset),
    .mem_valid   (mem_valid),
    .mem_write   (mem_write),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_ready   (mem_ready),
    .mem_rvalid  (mem_rvalid),
    .mem_rdata   (mem_rdata),
    .active      (active),
    .register_v0 (register_v0)
  );

  always #(clk_period_ns / 2) clk = ~clk;

  function automatic word_t next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return {16'b0, rng_state[31:16]};  // upper bits, the low ones cycle fast
  endfunction

  // byte at address +i is the i-th most significant byte of the value
  function automatic word_t to_bus_lanes(input word_t value);
    word_t lanes;
    for (int i = 0; i < 4; i++) begin
      lanes[8*i +: 8] = value[31-8*i -: 8];
    end
    return lanes;
  endfunction

  function automatic word_t read_word(input word_t addr);
    return mem.exists(addr) ? mem[addr] : (32'hDEAD0000 ^ addr);
  endfunction

  function automatic word_t r_type(input reg_addr_t rs, input reg_addr_t rt, input reg_addr_t rd,
                                   input logic [4:0] shamt, input logic [5:0] funct);
    return {op_special, rs, rt, rd, shamt, funct};
  endfunction

  function automatic word_t i_type(input logic [5:0] op, input reg_addr_t rs, input reg_addr_t rt,
                                   input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t j_type(input word_t target);
    return {op_j, target[27:2]};
  endfunction

  always @(posedge clk) begin : memory_model
    word_t r;
    if (reset) begin
      mem_ready    <= 1'b0;
      mem_rvalid   <= 1'b0;
      read_pending = 1'b0;
      seen_request = 1'b0;
      stretch      = 0;
    end else begin
      r = next_random();
      mem_rvalid <= 1'b0;
      if (mem_valid && mem_ready) begin
        if (!seen_request) begin
          first_addr   = mem_addr;
          first_write  = mem_write;
          seen_request = 1'b1;
        end
        if (mem_write) begin
          mem[mem_addr] = mem_wdata;  // writes complete at acceptance
        end else begin
          read_pending = 1'b1;
          read_addr    = mem_addr;
          read_delay   = 1 + int'(r % 4);
        end
      end
      if (read_pending) begin
        if (read_delay == 1) begin
          mem_rvalid   <= 1'b1;
          mem_rdata    <= read_word(read_addr);
          read_pending = 1'b0;
        end else begin
          read_delay--;
        end
      end
      if (!stall_mode) begin
        mem_ready <= (r[5:4] != 2'b00);  // ready three cycles in four
      end else if (stretch == 0) begin
        mem_ready <= !mem_ready;
        stretch   = mem_ready ? 4 + int'(r % 16) : 1 + int'(r % 3);
      end else begin
        stretch--;
      end
    end
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      abort_run($sformatf("error at %0t ns: %s is %h, expected %h",
                          $time, name, actual, expected));
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic add_instr(input word_t instr);
    program_q.push_back(instr);
  endtask

  task automatic run_program();
    foreach (program_q[i]) begin
      mem[reset_vector + 4 * i] = to_bus_lanes(program_q[i]);
    end
    apply_reset();
    while (active) @(posedge clk);  // halt is the done signal, the watchdog bounds it
  endtask

  task automatic alu_program();
    mem.delete();
    program_q.delete();
    add_instr(i_type(op_lui, r_zero, r_t0, 16'h1234));
    add_instr(i_type(op_ori, r_t0, r_t0, 16'h5678));
    add_instr(i_type(op_lui, r_zero, r_t1, 16'hF0F0));
    add_instr(i_type(op_ori, r_t1, r_t1, 16'h0F0F));
    add_instr(r_type(r_t0, r_t1, r_v0, 5'd0, fn_addu));
    add_instr(r_type(r_t0, r_t1, r_t2, 5'd0, fn_subu));
    add_instr(r_type(r_v0, r_t2, r_v0, 5'd0, fn_xor));
    add_instr(r_type(r_t0, r_t1, r_t2, 5'd0, fn_and));
    add_instr(r_type(r_v0, r_t2, r_v0, 5'd0, fn_addu));
    add_instr(r_type(r_t0, r_t1, r_t2, 5'd0, fn_or));
    add_instr(r_type(r_v0, r_t2, r_v0, 5'd0, fn_xor));
    add_instr(r_type(r_t1, r_t0, r_t2, 5'd0, fn_slt));   // negative < positive
    add_instr(r_type(r_zero, r_t2, r_t2, 5'd4, fn_sll));
    add_instr(r_type(r_v0, r_t2, r_v0, 5'd0, fn_addu));
    add_instr(r_type(r_t0, r_t1, r_t2, 5'd0, fn_sltu));
    add_instr(r_type(r_zero, r_t2, r_t2, 5'd9, fn_sll));
    add_instr(r_type(r_v0, r_t2, r_v0, 5'd0, fn_addu));
    add_instr(r_type(r_zero, r_t1, r_t3, 5'd7, fn_srl));
    add_instr(r_type(r_v0, r_t3, r_v0, 5'd0, fn_xor));
    add_instr(r_type(r_zero, r_t0, r_t3, 5'd13, fn_sll));
    add_instr(r_type(r_v0, r_t3, r_v0, 5'd0, fn_subu));
    add_instr(r_type(r_zero, r_zero, r_zero, 5'd0, fn_jr));
    run_program();
  endtask

  function automatic word_t alu_expected();
    word_t t0;
    word_t t1;
    word_t v0;
    t0 = 32'h12345678;
    t1 = 32'hF0F00F0F;
    v0 = t0 + t1;
    v0 = v0 ^ (t0 - t1);
    v0 = v0 + (t0 & t1);
    v0 = v0 ^ (t0 | t1);
    v0 = v0 + (($signed(t1) < $signed(t0)) ? 32'd1 << 4 : 32'd0);
    v0 = v0 + ((t0 < t1) ? 32'd1 << 9 : 32'd0);
    v0 = v0 ^ (t1 >> 7);
    return v0 - (t0 << 13);
  endfunction

  task automatic alu_instructions();
    $display("alu instructions");
    alu_program();
    check_value("register_v0", register_v0, alu_expected());
  endtask

  task automatic immediate_instructions();
    word_t t0;
    word_t v0;
    $display("immediate instructions");
    mem.delete();
    program_q.delete();
    add_instr(i_type(op_lui, r_zero, r_v0, 16'hDEAD));
    add_instr(i_type(op_ori, r_v0, r_v0, 16'hBEEF));
    add_instr(i_type(op_addiu, r_zero, r_t0, 16'hFFFB));  // -5
    add_instr(r_type(r_v0, r_t0, r_v0, 5'd0, fn_addu));
    add_instr(i_type(op_andi, r_t0, r_t1, 16'hFF00));
    add_instr(r_type(r_v0, r_t1, r_v0, 5'd0, fn_xor));
    add_instr(i_type(op_xori, r_t0, r_t2, 16'h8001));
    add_instr(r_type(r_v0, r_t2, r_v0, 5'd0, fn_addu));
    add_instr(i_type(op_slti, r_t0, r_t3, 16'hFFFC));  // -5 < -4
    add_instr(i_type(op_slti, r_t0, r_t1, 16'hFFFA));  // -5 < -6 is false
    add_instr(r_type(r_zero, r_t3, r_t3, 5'd8, fn_sll));
    add_instr(r_type(r_v0, r_t3, r_v0, 5'd0, fn_addu));
    add_instr(r_type(r_v0, r_t1, r_v0, 5'd0, fn_addu));
    add_instr(r_type(r_zero, r_zero, r_zero, 5'd0, fn_jr));
    run_program();
    t0 = 32'hFFFFFFFB;
    v0 = 32'hDEADBEEF + t0;
    v0 = v0 ^ (t0 & 32'h0000FF00);     // andi zero-extends
    v0 = v0 + (t0 ^ 32'h00008001);     // so does xori
    v0 = v0 + (($signed(t0) < -4) ? 32'd1 << 8 : 32'd0);
    v0 = v0 + (($signed(t0) < -6) ? 32'd1 : 32'd0);
    check_value("register_v0", register_v0, v0);
  endtask

  task automatic load_store();
    $display("loads and stores");
    mem.delete();
    program_q.delete();
    add_instr(i_type(op_lui, r_zero, r_t0, 16'hBFC0));
    add_instr(i_type(op_ori, r_t0, r_t0, 16'h0100));   // data area
    add_instr(i_type(op_lui, r_zero, r_t1, 16'h1122));
    add_instr(i_type(op_ori, r_t1, r_t1, 16'h3344));
    add_instr(i_type(op_sw, r_t0, r_t1, 16'd4));
    add_instr(i_type(op_lw, r_t0, r_v0, 16'd0));
    add_instr(i_type(op_lw, r_t0, r_t2, 16'd4));
    add_instr(i_type(op_sw, r_t0, r_t2, 16'd8));
    add_instr(r_type(r_zero, r_zero, r_zero, 5'd0, fn_jr));
    mem[32'hBFC00100] = 32'h3412FECA;  // bytes CA FE 12 34 from low to high address
    run_program();
    check_value("register_v0", register_v0, 32'hCAFE1234);
    check_value("mem[bfc00104]", read_word(32'hBFC00104), 32'h44332211);
    check_value("mem[bfc00108]", read_word(32'hBFC00108), 32'h44332211);
  endtask

  task automatic control_flow();
    $display("control flow");
    mem.delete();
    program_q.delete();
    add_instr(i_type(op_addiu, r_zero, r_t0, 16'd5));
    add_instr(i_type(op_addiu, r_v0, r_v0, 16'd3));       // loop body at index 1
    add_instr(i_type(op_addiu, r_t0, r_t0, 16'hFFFF));
    add_instr(i_type(op_bne, r_t0, r_zero, 16'hFFFD));    // back to index 1
    add_instr(i_type(op_beq, r_t0, r_zero, 16'd1));       // taken, skips the next one
    add_instr(i_type(op_addiu, r_v0, r_v0, 16'd100));
    add_instr(i_type(op_beq, r_v0, r_zero, 16'd1));       // not taken
    add_instr(i_type(op_addiu, r_v0, r_v0, 16'd1000));
    add_instr(j_type(reset_vector + 32'd40));
    add_instr(i_type(op_addiu, r_v0, r_v0, 16'd7));
    add_instr(r_type(r_zero, r_v0, r_v0, 5'd1, fn_sll));  // index 10
    add_instr(r_type(r_zero, r_zero, r_zero, 5'd0, fn_jr));
    run_program();
    check_value("register_v0", register_v0, (5 * 3 + 1000) * 2);
  endtask

  task automatic boot_and_halt();
    $display("boot and halt");
    mem.delete();
    program_q.delete();
    add_instr(i_type(op_addiu, r_zero, r_v0, 16'h0055));
    add_instr(r_type(r_zero, r_zero, r_zero, 5'd0, fn_jr));
    run_program();
    check_value("register_v0", register_v0, 32'h55);
    check_value("first mem_addr", first_addr, reset_vector);
    check_value("first mem_write", first_write, 0);
    repeat (20) begin
      @(posedge clk);
      check_value("mem_valid", mem_valid, 0);
      check_value("active", active, 0);
    end
  endtask

  task automatic back_pressure();
    $display("back-pressure");
    stall_mode = 1'b1;
    alu_program();
    stall_mode = 1'b0;
    check_value("register_v0", register_v0, alu_expected());
  endtask

  initial begin : watchdog
    #(watchdog_ns);
    abort_run($sformatf("timeout: tests still running after %0d ns", watchdog_ns));
  end

  initial begin : assertion_watch
    wait (uut.u_control.u_props.error_count != 0);
    abort_run("an assertion on the control FSM failed");
  end

  initial begin : main
    reset      = 1'b1;
    mem_ready  = 1'b0;
    mem_rvalid = 1'b0;
    mem_rdata  = '0;
    alu_instructions();
    immediate_instructions();
    load_store();
    control_flow();
    boot_and_halt();
    back_pressure();
    if (uut.u_control.u_props.error_count == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Test FAILED");
      $fatal(1, "assertion failures in the control FSM");
    end
  end

endmodule
